// File: fd_pkg.sv
package fd_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// frame geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int ORI_W        = 16;          // camera frame width.
	localparam int ORI_H        = 16;
	localparam int RES_W        = ORI_W / 2;   // 2:1 box resize.
	localparam int RES_H        = ORI_H / 2;
	localparam int WIN_SIZE     = 4;           // square search window side.
	localparam int NUM_FEATURES = 4;

	localparam int PIX_W = 8;
	localparam int II_W  = 14;                 // holds 64 * 255.
	localparam int SUM_W = 13;                 // rectangle difference and stage totals.
	localparam int VAL_W = 6;                  // feature votes and stage thresholds.

	typedef logic [3:0]                        coord_t;
	typedef logic [$clog2(NUM_FEATURES)-1:0]   feat_idx_t;
	typedef logic signed [SUM_W-1:0]           sum_t;
	typedef logic signed [VAL_W-1:0]           val_t;

	typedef struct packed {
		logic [PIX_W-1:0] pixel;
		coord_t           x;
		coord_t           y;
	} pix_beat_t;

	// rectangles are relative to the window origin.
	typedef struct packed {
		logic [2:0] x;
		logic [2:0] y;
		logic [2:0] w;
		logic [2:0] h;
	} rect_t;

	typedef struct packed {
		rect_t rect_a;                         // summed with a plus sign.
		rect_t rect_b;                         // summed with a minus sign.
		sum_t  threshold;
		val_t  pass_val;
		val_t  fail_val;
		val_t  stage_thresh;                   // only read on the last feature of a stage.
		logic  last_in_stage;
		logic  last_feature;
	} haar_feature_t;

endpackage

// File: frame_scanner.sv
module frame_scanner
	import fd_pkg::*;
#(
	parameter int ORI_W = fd_pkg::ORI_W,
	parameter int ORI_H = fd_pkg::ORI_H,
	parameter int PIX_W = fd_pkg::PIX_W
)
(
	input  logic             clk_os,
	input  logic             i_rst_n,
	input  logic             i_pixel_valid,
	input  logic [PIX_W-1:0] i_pixel,
	input  logic             i_frame_done,
	output logic             o_pixel_request,
	output pix_beat_t        o_beat,
	output logic             o_beat_valid
);

	coord_t ori_x_q;
	coord_t ori_y_q;
	logic   frame_full_q;
	logic   accept;
	logic   last_pixel;

	assign accept          = i_pixel_valid && o_pixel_request;
	assign last_pixel      = (ori_x_q == coord_t'(ORI_W - 1)) && (ori_y_q == coord_t'(ORI_H - 1));
	assign o_pixel_request = ~frame_full_q;   // held low while the cascade searches.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// coordinate iteration
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_os)
	begin
		if (!i_rst_n)
		begin
			ori_x_q      <= '0;
			ori_y_q      <= '0;
			frame_full_q <= 1'b0;
			o_beat_valid <= 1'b0;
		end
		else
		begin
			o_beat_valid <= accept;
			if (accept)
			begin
				if (ori_x_q == coord_t'(ORI_W - 1))
				begin
					ori_x_q <= '0;
					if (ori_y_q == coord_t'(ORI_H - 1))
						ori_y_q <= '0;
					else
						ori_y_q <= ori_y_q + 1'b1;
				end
				else
					ori_x_q <= ori_x_q + 1'b1;
				if (last_pixel)
					frame_full_q <= 1'b1;   // 256th beat closes the frame.
			end
			if (i_frame_done)
				frame_full_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_os)
	begin
		if (accept)
			o_beat <= '{pixel: i_pixel, x: ori_x_q, y: ori_y_q};
	end

	a_no_beat_while_full: assert property (@(posedge clk_os) disable iff (!i_rst_n)
		i_pixel_valid |-> o_pixel_request)
		else $error("pixel beat sent while the request level is low");

endmodule

// File: pixel_resizer.sv
module pixel_resizer
	import fd_pkg::*;
#(
	parameter int ORI_W = fd_pkg::ORI_W,
	parameter int ORI_H = fd_pkg::ORI_H,
	parameter int PIX_W = fd_pkg::PIX_W
)
(
	input  logic      clk_os,
	input  logic      i_rst_n,
	input  pix_beat_t i_beat,
	input  logic      i_beat_valid,
	output pix_beat_t o_res_beat,
	output logic      o_res_valid
);

	localparam int LINE_AW = $clog2(RES_W);

	// the resized geometry comes from the package, so the ratio has to hold.
	if (ORI_W != 2 * RES_W || ORI_H != 2 * RES_H)
	begin : g_bad_ratio
		$error("pixel_resizer expects a 2:1 ratio to the package geometry.");
	end

	logic [PIX_W-1:0]   left_q;               // even-column pixel of the current pair.
	logic [PIX_W:0]     line_q [RES_W];       // pair sums of the even row above.
	logic [PIX_W:0]     pair_sum;
	logic [PIX_W+1:0]   block_sum;
	logic [LINE_AW-1:0] line_idx;
	logic               odd_col;
	logic               odd_row;

	assign odd_col   = i_beat.x[0];
	assign odd_row   = i_beat.y[0];
	assign line_idx  = LINE_AW'(i_beat.x >> 1);
	assign pair_sum  = {1'b0, left_q} + {1'b0, i_beat.pixel};
	assign block_sum = {1'b0, line_q[line_idx]} + {1'b0, pair_sum};

	always_ff @(posedge clk_os)
	begin
		if (!i_rst_n)
			o_res_valid <= 1'b0;
		else
			o_res_valid <= i_beat_valid && odd_col && odd_row;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// 2 x 2 box average
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_os)
	begin
		if (i_beat_valid)
		begin
			if (!odd_col)
				left_q <= i_beat.pixel;
			else if (!odd_row)
				line_q[line_idx] <= pair_sum;   // park the upper pair.
			else
				o_res_beat <= '{pixel: block_sum[PIX_W+1:2],
					x: i_beat.x >> 1,
					y: i_beat.y >> 1};          // truncating divide by four.
		end
	end

endmodule

// File: integral_builder.sv
module integral_builder
	import fd_pkg::*;
(
	input  logic            clk_os,
	input  logic            i_rst_n,
	input  pix_beat_t       i_res_beat,
	input  logic            i_res_valid,
	input  coord_t          i_rd_x,
	input  coord_t          i_rd_y,
	output logic [II_W-1:0] o_rd_data,
	output logic            o_ii_ready
);

	localparam int ADDR_W = $clog2(RES_W * RES_H);

	logic [II_W-1:0]   ii_mem [RES_W * RES_H];   // unpadded 8 x 8 integral image.
	pix_beat_t         wr_q;
	logic              wr_valid_q;
	logic              seen_q;                   // a beat has been written since reset.
	logic [II_W-1:0]   row_sum_q;
	logic [II_W-1:0]   row_next;
	logic [II_W-1:0]   above;
	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] res_addr;
	logic [ADDR_W-1:0] rd_addr;

	assign wr_addr  = ADDR_W'(wr_q.y * RES_W + wr_q.x);
	assign res_addr = ADDR_W'(i_res_beat.y * RES_W + i_res_beat.x);
	assign rd_addr  = ADDR_W'((i_rd_y - 1'b1) * RES_W + (i_rd_x - 1'b1));
	assign row_next = (wr_q.x == '0 ? '0 : row_sum_q) + II_W'(wr_q.pixel);
	assign above    = (wr_q.y == '0) ? '0 : ii_mem[ADDR_W'(wr_addr - RES_W)];

	always_ff @(posedge clk_os)
	begin
		if (!i_rst_n)
		begin
			wr_valid_q <= 1'b0;
			seen_q     <= 1'b0;
			o_ii_ready <= 1'b0;
		end
		else
		begin
			wr_valid_q <= i_res_valid;
			seen_q     <= seen_q | wr_valid_q;
			o_ii_ready <= wr_valid_q && (wr_addr == ADDR_W'(RES_W * RES_H - 1));
		end
	end

	always_ff @(posedge clk_os)
	begin
		if (i_res_valid)
			wr_q <= i_res_beat;
		if (wr_valid_q)
		begin
			row_sum_q        <= row_next;
			ii_mem[wr_addr] <= row_next + above;   // II(x,y) = row sum + entry above.
		end
		// padded read port, row 0 and column 0 read as zero.
		o_rd_data <= (i_rd_x == '0 || i_rd_y == '0) ? '0 : ii_mem[rd_addr];
	end

	a_raster_order: assert property (@(posedge clk_os) disable iff (!i_rst_n)
		i_res_valid && seen_q |-> res_addr == ADDR_W'(wr_addr + 1'b1))
		else $error("resized beat out of raster order");

endmodule

// File: haar_database.sv
module haar_database
	import fd_pkg::*;
(
	input  feat_idx_t     i_feat_idx,
	output haar_feature_t o_feature
);

	localparam logic [2:0] FULL = 3'(WIN_SIZE);
	localparam logic [2:0] HALF = 3'(WIN_SIZE / 2);

	function automatic rect_t mk_rect(input logic [2:0] x, input logic [2:0] y,
		input logic [2:0] w, input logic [2:0] h);
		rect_t r;
		r = '{x: x, y: y, w: w, h: h};
		return r;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// feature table, stage 0 is features 0 and 1, stage 1 is 2 and 3
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		o_feature = '0;
		case (i_feat_idx)
			2'd0:
			begin
				o_feature.rect_a    = mk_rect(3'd0, 3'd0, FULL, HALF);   // top half.
				o_feature.rect_b    = mk_rect(3'd0, HALF, FULL, HALF);   // bottom half.
				o_feature.threshold = 13'sd32;
				o_feature.pass_val  = 6'sd2;
				o_feature.fail_val  = -6'sd1;
			end
			2'd1:
			begin
				o_feature.rect_a        = mk_rect(3'd0, 3'd0, HALF, FULL);   // left half.
				o_feature.rect_b        = mk_rect(HALF, 3'd0, HALF, FULL);
				o_feature.threshold     = -13'sd16;
				o_feature.pass_val      = 6'sd1;
				o_feature.fail_val      = -6'sd1;
				o_feature.stage_thresh  = 6'sd2;
				o_feature.last_in_stage = 1'b1;
			end
			2'd2:
			begin
				o_feature.rect_a    = mk_rect(3'd0, 3'd1, FULL, 3'd2);   // centre rows.
				o_feature.rect_b    = mk_rect(3'd0, 3'd0, FULL, 3'd1);   // top row.
				o_feature.threshold = 13'sd0;
				o_feature.pass_val  = 6'sd1;
				o_feature.fail_val  = -6'sd2;
			end
			default:
			begin
				o_feature.rect_a        = mk_rect(3'd0, 3'd0, FULL, FULL);
				o_feature.rect_b        = mk_rect(3'd0, 3'd0, 3'd1, FULL);   // left column.
				o_feature.threshold     = 13'sd64;
				o_feature.pass_val      = 6'sd1;
				o_feature.fail_val      = -6'sd1;
				o_feature.stage_thresh  = 6'sd1;
				o_feature.last_in_stage = 1'b1;
				o_feature.last_feature  = 1'b1;
			end
		endcase
	end

endmodule

// File: cascade_eval.sv
module cascade_eval
	import fd_pkg::*;
(
	input  logic            clk_os,
	input  logic            i_rst_n,
	input  logic            i_ii_ready,
	input  logic [II_W-1:0] i_rd_data,
	input  haar_feature_t   i_feature,
	output coord_t          o_rd_x,
	output coord_t          o_rd_y,
	output feat_idx_t       o_feat_idx,
	output logic            o_candidate,
	output coord_t          o_cand_x,
	output coord_t          o_cand_y,
	output logic            o_frame_done
);

	localparam coord_t WIN_LAST_X = coord_t'(RES_W - WIN_SIZE);
	localparam coord_t WIN_LAST_Y = coord_t'(RES_H - WIN_SIZE);

	typedef enum logic [1:0] {S_IDLE, S_READ, S_EVAL, S_NEXT} state_t;

	state_t     state_q;
	coord_t     wx_q;
	coord_t     wy_q;
	feat_idx_t  feat_q;
	logic [3:0] step_q;          // 0..7 issue corner reads and 1..8 take their data.
	logic       neg_q;           // sign of the corner read in flight.
	sum_t       diff_q;          // rect_a sum minus rect_b sum.
	sum_t       stage_q;
	rect_t      rect;
	logic [1:0] corner;
	sum_t       rd_val;
	sum_t       feat_thr;
	val_t       stage_thr;
	val_t       contrib;
	sum_t       stage_next;

	// corner 0 is (x+w, y+h), 1 is (x, y+h), 2 is (x+w, y), 3 is (x, y).
	assign corner     = step_q[1:0];
	assign rect       = step_q[2] ? i_feature.rect_b : i_feature.rect_a;
	assign o_rd_x     = wx_q + coord_t'(rect.x) + (corner[0] ? 4'd0 : coord_t'(rect.w));
	assign o_rd_y     = wy_q + coord_t'(rect.y) + (corner[1] ? 4'd0 : coord_t'(rect.h));
	assign o_feat_idx = feat_q;

	// partial sums wrap in SUM_W bits but the finished difference always fits.
	assign rd_val     = sum_t'(i_rd_data);
	assign feat_thr   = i_feature.threshold;
	assign stage_thr  = i_feature.stage_thresh;
	assign contrib    = (diff_q >= feat_thr) ? i_feature.pass_val : i_feature.fail_val;
	assign stage_next = stage_q + contrib;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// window / feature / corner FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_os)
	begin
		if (!i_rst_n)
		begin
			state_q      <= S_IDLE;
			wx_q         <= '0;
			wy_q         <= '0;
			feat_q       <= '0;
			step_q       <= '0;
			neg_q        <= 1'b0;
			diff_q       <= '0;
			stage_q      <= '0;
			o_candidate  <= 1'b0;
			o_frame_done <= 1'b0;
		end
		else
		begin
			o_candidate  <= 1'b0;
			o_frame_done <= 1'b0;
			case (state_q)
				S_IDLE:
				if (i_ii_ready)
				begin
					{wx_q, wy_q, feat_q, step_q, stage_q} <= '0;
					state_q <= S_READ;
				end
				S_READ:
				begin
					neg_q <= corner[0] ^ corner[1] ^ step_q[2];   // rect_b flips the sign.
					if (step_q == 4'd0)
						diff_q <= '0;
					else
						diff_q <= neg_q ? diff_q - rd_val : diff_q + rd_val;
					step_q <= (step_q == 4'd8) ? 4'd0 : step_q + 1'b1;
					if (step_q == 4'd8)
						state_q <= S_EVAL;
				end
				S_EVAL:
				if (i_feature.last_in_stage && stage_next < stage_thr)
					state_q <= S_NEXT;                // a failed stage drops the window.
				else if (i_feature.last_feature)
				begin
					o_candidate <= 1'b1;
					o_cand_x    <= wx_q;
					o_cand_y    <= wy_q;
					state_q     <= S_NEXT;
				end
				else
				begin
					feat_q  <= feat_q + 1'b1;
					stage_q <= i_feature.last_in_stage ? '0 : stage_next;
					state_q <= S_READ;
				end
				default:
				begin
					feat_q  <= '0;
					stage_q <= '0;
					state_q <= S_READ;
					if (wx_q != WIN_LAST_X)
						wx_q <= wx_q + 1'b1;
					else
					begin
						wx_q <= '0;
						wy_q <= wy_q + 1'b1;
						if (wy_q == WIN_LAST_Y)
						begin
							o_frame_done <= 1'b1;   // last window (4, 4) is done.
							state_q      <= S_IDLE;
						end
					end
				end
			endcase
		end
	end

	a_ready_while_idle: assert property (@(posedge clk_os) disable iff (!i_rst_n)
		i_ii_ready |-> state_q == S_IDLE)
		else $error("integral image ready while a window search is still running");

endmodule

// File: face_detect_top.sv
module face_detect_top
	import fd_pkg::*;
#(
	parameter int ORI_W = fd_pkg::ORI_W,
	parameter int ORI_H = fd_pkg::ORI_H,
	parameter int PIX_W = fd_pkg::PIX_W
)
(
	input  logic             clk_os,
	input  logic             i_rst_n,
	input  logic             i_pixel_valid,
	input  logic [PIX_W-1:0] i_pixel,
	output logic             o_pixel_request,
	output logic             o_candidate,
	output coord_t           o_cand_x,
	output coord_t           o_cand_y,
	output logic             o_frame_done
);

	pix_beat_t       scan_beat;
	logic            scan_valid;
	pix_beat_t       res_beat;
	logic            res_valid;
	coord_t          ii_rd_x;
	coord_t          ii_rd_y;
	logic [II_W-1:0] ii_rd_data;
	logic            ii_ready;
	feat_idx_t       feat_idx;
	haar_feature_t   feature;

	frame_scanner #(.ORI_W(ORI_W), .ORI_H(ORI_H), .PIX_W(PIX_W)) i_frame_scanner (
		.clk_os(clk_os), .i_rst_n(i_rst_n), .i_pixel_valid(i_pixel_valid),
		.i_pixel(i_pixel), .i_frame_done(o_frame_done), .o_pixel_request(o_pixel_request),
		.o_beat(scan_beat), .o_beat_valid(scan_valid));

	pixel_resizer #(.ORI_W(ORI_W), .ORI_H(ORI_H), .PIX_W(PIX_W)) i_pixel_resizer (
		.clk_os(clk_os), .i_rst_n(i_rst_n), .i_beat(scan_beat), .i_beat_valid(scan_valid),
		.o_res_beat(res_beat), .o_res_valid(res_valid));

	integral_builder i_integral_builder (
		.clk_os(clk_os), .i_rst_n(i_rst_n), .i_res_beat(res_beat), .i_res_valid(res_valid),
		.i_rd_x(ii_rd_x), .i_rd_y(ii_rd_y), .o_rd_data(ii_rd_data), .o_ii_ready(ii_ready));

	haar_database i_haar_database (.i_feat_idx(feat_idx), .o_feature(feature));

	cascade_eval i_cascade_eval (
		.clk_os(clk_os), .i_rst_n(i_rst_n), .i_ii_ready(ii_ready), .i_rd_data(ii_rd_data),
		.i_feature(feature), .o_rd_x(ii_rd_x), .o_rd_y(ii_rd_y), .o_feat_idx(feat_idx),
		.o_candidate(o_candidate), .o_cand_x(o_cand_x), .o_cand_y(o_cand_y),
		.o_frame_done(o_frame_done));

endmodule

// File: tb_face_detect.sv
module tb_face_detect
	import fd_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_FRAMES   = 4;
	localparam int NUM_WIN      = (RES_W - WIN_SIZE + 1) * (RES_H - WIN_SIZE + 1);
	localparam int FRAME_CYCLES = ORI_W * ORI_H * 4 + NUM_WIN * (NUM_FEATURES * 10 + 1) + 64;
	localparam int CYCLE_LIMIT  = 2 * (16 + 64 + NUM_FRAMES * FRAME_CYCLES);

	// feature table with rectangles as x, y, w, h in window units.
	localparam int RECT_A [4][4] = '{'{0, 0, 4, 2}, '{0, 0, 2, 4}, '{0, 1, 4, 2}, '{0, 0, 4, 4}};
	localparam int RECT_B [4][4] = '{'{0, 2, 4, 2}, '{2, 0, 2, 4}, '{0, 0, 4, 1}, '{0, 0, 1, 4}};
	localparam int FT_THR    [4] = '{32, -16, 0, 64};
	localparam int FT_PASS   [4] = '{2, 1, 1, 1};
	localparam int FT_FAIL   [4] = '{-1, -1, -2, -1};
	localparam int STAGE_THR [2] = '{2, 1};

	logic             clk_os;
	logic             i_rst_n;
	logic             i_pixel_valid;
	logic [PIX_W-1:0] i_pixel;
	logic             o_pixel_request;
	logic             o_candidate;
	coord_t           o_cand_x;
	coord_t           o_cand_y;
	logic             o_frame_done;

	logic [PIX_W-1:0] frame_buf [ORI_W * ORI_H];
	int               res_img [RES_H][RES_W];
	int               ii_img [RES_H + 1][RES_W + 1];   // padded with a zero row and column.
	coord_t           exp_x [128];
	coord_t           exp_y [128];
	int               exp_n = 0;
	int               exp_ptr;
	logic             head_valid;
	coord_t           head_x;
	coord_t           head_y;
	int               beat_cnt;
	logic             tb_full;                         // model of the frame-full flag.
	int               done_cnt;
	int               frames_sent = 0;
	int               cycle_cnt = 0;
	int               cand_err = 0;
	int               done_err = 0;
	int               req_err = 0;
	int               check_err = 0;
	int               tests_run = 0;
	int               tests_failed = 0;
	integer           seed;
	string            test_name = "none";

	face_detect_top i_face_detect_top (
		.clk_os(clk_os), .i_rst_n(i_rst_n), .i_pixel_valid(i_pixel_valid),
		.i_pixel(i_pixel), .o_pixel_request(o_pixel_request), .o_candidate(o_candidate),
		.o_cand_x(o_cand_x), .o_cand_y(o_cand_y), .o_frame_done(o_frame_done));

	initial
	begin
		clk_os = 1'b0;
		forever #20 clk_os = ~clk_os;
	end

	assign head_valid = exp_ptr < exp_n;
	assign head_x     = exp_x[exp_ptr % 128];
	assign head_y     = exp_y[exp_ptr % 128];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// monitors and checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(posedge clk_os)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (!i_rst_n)
		begin
			beat_cnt <= 0;
			tb_full  <= 1'b0;
			done_cnt <= 0;
			exp_ptr  <= 0;
		end
		else
		begin
			if (i_pixel_valid && o_pixel_request)
			begin
				beat_cnt <= (beat_cnt + 1) % (ORI_W * ORI_H);
				if (beat_cnt == ORI_W * ORI_H - 1)
					tb_full <= 1'b1;                  // last beat of the frame.
			end
			if (o_frame_done)
			begin
				tb_full  <= 1'b0;
				done_cnt <= done_cnt + 1;
			end
			if (o_candidate)
				exp_ptr <= exp_ptr + 1;
		end
	end

	a_cand_match: assert property (@(posedge clk_os) disable iff (!i_rst_n)
		o_candidate |-> head_valid && o_cand_x == head_x && o_cand_y == head_y)
		else
		begin
			cand_err++;
			if (!$sampled(head_valid))
				$display("candidate at (%0d,%0d) in test %s was not expected",
					$sampled(o_cand_x), $sampled(o_cand_y), test_name);
			else
				$display("mismatch test %s: expected (%0d,%0d) actual (%0d,%0d)", test_name,
					$sampled(head_x), $sampled(head_y), $sampled(o_cand_x), $sampled(o_cand_y));
		end

	a_done_clean: assert property (@(posedge clk_os) disable iff (!i_rst_n)
		o_frame_done |-> !head_valid)
		else
		begin
			done_err++;
			$display("frame done in test %s while expected candidates were never reported",
				test_name);
		end

	a_request_level: assert property (@(posedge clk_os) disable iff (!i_rst_n)
		o_pixel_request == !tb_full)
		else
		begin
			req_err++;
			$display("mismatch test %s: expected request %0d actual %0d", test_name,
				!$sampled(tb_full), $sampled(o_pixel_request));
		end

	initial
	begin
		wait (cycle_cnt >= CYCLE_LIMIT);
		$display("timeout after %0d cycles, the frame search never finished", cycle_cnt);
		$display("Simulation failed");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic int total_errors();
		return cand_err + done_err + req_err + check_err;
	endfunction

	function automatic int rect_sum(int wx, int wy, int x, int y, int w, int h);
		return ii_img[wy + y + h][wx + x + w] - ii_img[wy + y + h][wx + x]
			- ii_img[wy + y][wx + x + w] + ii_img[wy + y][wx + x];
	endfunction

	function automatic int feature_vote(int f, int wx, int wy);
		int diff;
		diff = rect_sum(wx, wy, RECT_A[f][0], RECT_A[f][1], RECT_A[f][2], RECT_A[f][3])
			- rect_sum(wx, wy, RECT_B[f][0], RECT_B[f][1], RECT_B[f][2], RECT_B[f][3]);
		return (diff >= FT_THR[f]) ? FT_PASS[f] : FT_FAIL[f];
	endfunction

	function automatic bit window_passes(int wx, int wy);
		if (feature_vote(0, wx, wy) + feature_vote(1, wx, wy) < STAGE_THR[0])
			return 1'b0;                               // stage 0 rejects early.
		return feature_vote(2, wx, wy) + feature_vote(3, wx, wy) >= STAGE_THR[1];
	endfunction

	task automatic append_expected();
		int sum;
		for (int y = 0; y < RES_H; y++)
			for (int x = 0; x < RES_W; x++)
			begin
				sum = int'(frame_buf[2 * y * ORI_W + 2 * x])
					+ int'(frame_buf[2 * y * ORI_W + 2 * x + 1])
					+ int'(frame_buf[(2 * y + 1) * ORI_W + 2 * x])
					+ int'(frame_buf[(2 * y + 1) * ORI_W + 2 * x + 1]);
				res_img[y][x] = sum / 4;
			end
		for (int y = 0; y <= RES_H; y++)
			for (int x = 0; x <= RES_W; x++)
				if (x == 0 || y == 0)
					ii_img[y][x] = 0;
				else
					ii_img[y][x] = res_img[y - 1][x - 1] + ii_img[y - 1][x]
						+ ii_img[y][x - 1] - ii_img[y - 1][x - 1];
		for (int wy = 0; wy <= RES_H - WIN_SIZE; wy++)
			for (int wx = 0; wx <= RES_W - WIN_SIZE; wx++)
				if (window_passes(wx, wy))
				begin
					exp_x[exp_n % 128] = 4'(wx);
					exp_y[exp_n % 128] = 4'(wy);
					exp_n = exp_n + 1;
				end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic build_frame(input int kind);
		logic [31:0] rnd;
		for (int y = 0; y < ORI_H; y++)
			for (int x = 0; x < ORI_W; x++)
				case (kind)
					0: frame_buf[y * ORI_W + x] = 8'd100;
					1: frame_buf[y * ORI_W + x] = (x < 2) ? 8'd220 : ((y < 8) ? 8'd200 : 8'd20);
					2:
					begin
						rnd = $random(seed);
						frame_buf[y * ORI_W + x] = rnd[PIX_W-1:0];
					end
					default: ;                         // resend the frame already held.
				endcase
	endtask

	task automatic send_frame(input bit gaps);
		int i;
		logic [31:0] rnd;
		i = 0;
		while (i < ORI_W * ORI_H)
		begin
			@(posedge clk_os);
			rnd = $random(seed);
			if (o_pixel_request && !(gaps && rnd[1:0] == 2'd0))
			begin
				i_pixel_valid <= 1'b1;
				i_pixel       <= frame_buf[i];
				i = i + 1;
			end
			else
				i_pixel_valid <= 1'b0;
		end
		@(posedge clk_os);
		i_pixel_valid <= 1'b0;
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_run++;
		if (total_errors() > err_before)
		begin
			tests_failed++;
			$display("test %-14s failed with %0d errors", name, total_errors() - err_before);
		end
		else
			$display("test %-14s passed", name);
	endtask

	task automatic run_frame_test(input string name, input int kind, input bit gaps);
		int err_before;
		int done_before;
		test_name   = name;
		err_before  = total_errors();
		build_frame(kind);
		append_expected();
		done_before = done_cnt;
		send_frame(gaps);
		while (done_cnt == done_before)
			@(posedge clk_os);
		frames_sent++;
		report_test(name, err_before);
	endtask

	initial
	begin
		int err_before;
		i_rst_n       = 1'b0;
		i_pixel_valid = 1'b0;
		i_pixel       = '0;
		seed          = 32'hfb4b;
		test_name     = "reset";
		err_before    = total_errors();
		repeat (16) @(posedge clk_os);
		assert (!o_candidate && !o_frame_done && o_pixel_request)
		else
		begin
			check_err++;
			$display("mismatch test %s: expected cand/done/req %b actual %b", test_name,
				3'b001, {o_candidate, o_frame_done, o_pixel_request});
		end
		i_rst_n <= 1'b1;
		repeat (20) @(posedge clk_os);                // no candidate may show up here.
		report_test("reset", err_before);

		run_frame_test("flat_frame", 0, 1'b0);
		run_frame_test("pattern_frame", 1, 1'b0);
		run_frame_test("random_gaps", 2, 1'b1);
		run_frame_test("back_to_back", 3, 1'b0);      // same frame again without an idle gap.

		test_name  = "frame_count";
		err_before = total_errors();
		assert (done_cnt == frames_sent)
		else
		begin
			check_err++;
			$display("mismatch test %s: expected %0d actual %0d", test_name, frames_sent, done_cnt);
		end
		report_test("frame_count", err_before);

		$display("tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, total_errors());
		if (tests_failed == 0 && total_errors() == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: flist.f
fd_pkg.sv
frame_scanner.sv
pixel_resizer.sv
integral_builder.sv
haar_database.sv
cascade_eval.sv
face_detect_top.sv
tb_face_detect.sv

// File: Makefile
SIM       = verilator
FLAGS     = --binary --assert --timescale 1ns/100ps -j 0
TOP       = tb_face_detect
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation failed
PASS_MSG  = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP), result taken from $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test run FAILED"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
